/* build.f */
+incdir+include
+incdir+bench
design/rot_stream_pkg.sv
design/rot_cfg_pkg.sv
design/rot_cfg_decode.sv
design/rot_pingpong_bank.sv
design/rot_loop_counters.sv
design/weight_rotator.sv
bench/tb_weight_rotator.sv

/* Makefile */
# Verilator build and run for the weight rotator testbench

VERILATOR ?= verilator
TOP       ?= tb_weight_rotator
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

PASS_MSG = TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "help     show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# the run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_rot_model.svh */
`ifndef TB_ROT_MODEL_SVH
`define TB_ROT_MODEL_SVH

// one expected output beat
typedef struct packed {
  row_t      row;
  logic      last;
  out_user_t user;
} beat_t;

// expected beats of all accepted blocks, in order
beat_t exp_q[$];

// first pass replays with its own address limit
function automatic int pick_addr_max(input hdr_t hdr);
  return hdr.is_first_p ? int'(hdr.addr_p0_max) : int'(hdr.addr_p_max);
endfunction

// and with its own channel count
function automatic int pick_cin_1(input hdr_t hdr);
  return hdr.is_first_p ? int'(hdr.cin_p0_1) : int'(hdr.cin_p_1);
endfunction

// expand one accepted block into its whole replay
task automatic expand_block(input hdr_t hdr, input row_t rows[$]);
  int    addr_max;
  int    cin_1;
  int    cols_1;
  int    kw2;
  int    taps;
  int    beats;
  int    i;
  int    tap;
  int    cin;
  int    col;
  beat_t b;
  addr_max = pick_addr_max(hdr);
  cin_1    = pick_cin_1(hdr);
  cols_1   = int'(hdr.cols_1);
  kw2      = int'(hdr.kw2);
  taps     = 2 * kw2 + 1;
  beats    = taps * (cin_1 + 1) * (cols_1 + 1) * (int'(hdr.blocks_1) + 1)
             * (int'(hdr.xn_1) + 1);
  for (i = 0; i < beats; i++) begin
    // taps innermost, then channels, then columns
    tap = i % taps;
    cin = (i / taps) % (cin_1 + 1);
    col = (i / (taps * (cin_1 + 1))) % (cols_1 + 1);
    b.row                 = rows[i % (addr_max + 1)];
    b.last                = (i == beats - 1);
    b.user.kw2            = hdr.kw2;
    b.user.is_w_first_clk = (tap == 0) && (cin == 0) && (col == 0);
    b.user.is_cin_last    = (tap == taps - 1) && (cin == cin_1);
    b.user.is_w_first_kw2 = (cols_1 - col) < kw2;
    b.user.is_w_last      = (col == cols_1);
    exp_q.push_back(b);
  end
endtask

`endif

/* bench/tb_weight_rotator.sv */
`timescale 1ns/100ps
`include "rot_settings.svh"

module tb_weight_rotator
  import rot_stream_pkg::*, rot_cfg_pkg::*;
();

  localparam int NUM_BLOCKS = 12;
  localparam int WAIT_LIMIT = 20000;

  logic      aclk = 1'b0;
  logic      aresetn;
  logic      i_s_valid;
  logic      o_s_ready;
  logic      i_s_last;
  row_t      i_s_data;
  hdr_t      i_s_user;
  logic      o_m_valid;
  logic      i_m_ready = 1'b0;
  row_t      o_m_data;
  logic      o_m_last;
  out_user_t o_m_user;

  int n_checks   = 0;
  int n_errors   = 0;
  int n_timeouts = 0;
  int n_beats    = 0;
  int n_pending  = 0;

  `include "tb_rot_model.svh"

  beat_t mon_beat;
  beat_t held;
  logic  held_stall = 1'b0;

  weight_rotator u_weight_rotator (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_user  (i_s_user),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  always #20 aclk = ~aclk;

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic hdr_t random_header();
    hdr_t hdr;
    hdr.addr_p_max  = addr_t'($urandom_range(`ROT_DEPTH - 1, 0));
    hdr.addr_p0_max = addr_t'($urandom_range(`ROT_DEPTH - 1, 0));
    hdr.xn_1        = xn_t'($urandom_range(`ROT_XN_MAX - 1, 0));
    hdr.cin_p_1     = ci_t'($urandom_range(`ROT_CI_MAX - 1, 0));
    hdr.cin_p0_1    = ci_t'($urandom_range(`ROT_CI_MAX - 1, 0));
    hdr.blocks_1    = blk_t'($urandom_range(`ROT_BLOCKS_MAX - 1, 0));
    hdr.cols_1      = xw_t'($urandom_range(`ROT_XW_MAX - 1, 0));
    hdr.kw2         = kw2_t'($urandom_range((`ROT_KW_MAX - 1) / 2, 0));
    hdr.is_first_p  = 1'($urandom_range(1, 0));
    return hdr;
  endfunction

  function automatic row_t random_row();
    row_t row;
    int   c;
    for (c = 0; c < `ROT_COLS; c++) begin
      row[c] = word_t'($urandom);
    end
    return row;
  endfunction

  // one input beat with an occasional gap before it
  task automatic send_beat(input row_t row, input logic last, input hdr_t hdr);
    int   cycles;
    logic accepted;
    if ($urandom_range(3, 0) == 0) begin
      i_s_valid = 1'b0;
      repeat ($urandom_range(3, 1)) @(posedge aclk);
      #2;
    end
    i_s_valid = 1'b1;
    i_s_data  = row;
    i_s_last  = last;
    i_s_user  = hdr;
    accepted  = 1'b0;
    cycles    = 0;
    while (!accepted && cycles < WAIT_LIMIT) begin
      @(negedge aclk);
      accepted = o_s_ready;
      @(posedge aclk);
      #2;
      cycles++;
    end
    if (!accepted) begin
      n_timeouts++;
      $display("timeout: input ready stayed low for %0d cycles", cycles);
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  // header only on the last beat and junk on the others
  task automatic send_block();
    hdr_t hdr;
    row_t rows[$];
    row_t row;
    int   n_rows;
    int   r;
    hdr    = random_header();
    // write enough rows for either address limit
    n_rows = (hdr.addr_p_max > hdr.addr_p0_max) ? int'(hdr.addr_p_max) + 1
                                                 : int'(hdr.addr_p0_max) + 1;
    for (r = 0; r < n_rows && n_timeouts == 0; r++) begin
      row = random_row();
      rows.push_back(row);
      send_beat(row, r == n_rows - 1, (r == n_rows - 1) ? hdr : random_header());
    end
    if (n_timeouts == 0) begin
      expand_block(hdr, rows);
      n_pending++;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(posedge aclk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      n_timeouts++;
      $display("timeout: %0d expected output beats never came", exp_q.size());
    end else begin
      // idle a while so stray beats reach the monitor
      repeat (16) @(posedge aclk);
      #2;
      check_value(64'(o_m_valid), 64'(0), "o_m_valid after the last block");
    end
  endtask

  // sink stalls about one beat in four
  always @(posedge aclk) begin
    #2;
    if (!aresetn) begin
      i_m_ready = 1'b0;
    end else begin
      i_m_ready = ($urandom_range(3, 0) != 0);
    end
  end

  // outputs sampled mid-cycle ahead of the handshake edge
  always @(negedge aclk) begin
    if (aresetn) begin
      if (held_stall) begin
        check_value(64'(o_m_valid), 64'(1), "o_m_valid under stall");
        check_value(64'(o_m_data), 64'(held.row), "o_m_data under stall");
        check_value(64'(o_m_last), 64'(held.last), "o_m_last under stall");
        check_value(64'(o_m_user), 64'(held.user), "o_m_user under stall");
      end
      // both banks hold a block that is not fully replayed
      if (n_pending >= 2) begin
        check_value(64'(o_s_ready), 64'(0), "o_s_ready with both banks full");
      end
      if (exp_q.size() == 0) begin
        check_value(64'(o_m_valid), 64'(0), "o_m_valid with no complete block stored");
      end else if (o_m_valid && i_m_ready) begin
        mon_beat = exp_q.pop_front();
        check_value(64'(o_m_data), 64'(mon_beat.row), "o_m_data");
        check_value(64'(o_m_last), 64'(mon_beat.last), "o_m_last");
        check_value(64'(o_m_user), 64'(mon_beat.user), "o_m_user");
        if (mon_beat.last) begin
          n_pending--;
        end
        n_beats++;
      end
      held_stall = o_m_valid && !i_m_ready;
      held.row   = o_m_data;
      held.last  = o_m_last;
      held.user  = o_m_user;
    end
  end

  initial begin
    int blk;
    int seed_sink;
    seed_sink = $urandom(32'hcc541ed5);
    aresetn   = 1'b0;
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    i_s_data  = '0;
    i_s_user  = '0;
    repeat (8) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    check_value(64'(o_m_valid), 64'(0), "o_m_valid after reset");
    check_value(64'(o_s_ready), 64'(0), "o_s_ready in the first cycle after reset");
    @(posedge aclk);
    #2;
    check_value(64'(o_s_ready), 64'(1), "o_s_ready with both banks free");
    for (blk = 0; blk < NUM_BLOCKS && n_timeouts == 0; blk++) begin
      send_block();
    end
    if (n_timeouts == 0) begin
      wait_drain();
    end
    $display("checks %0d, beats %0d, errors %0d, timeouts %0d",
             n_checks, n_beats, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* design/weight_rotator.sv */
`timescale 1ns/100ps

module weight_rotator
  import rot_stream_pkg::*, rot_cfg_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      i_s_valid,
  output logic      o_s_ready,
  input  logic      i_s_last,
  input  row_t      i_s_data,
  input  hdr_t      i_s_user,
  output logic      o_m_valid,
  input  logic      i_m_ready,
  output row_t      o_m_data,
  output logic      o_m_last,
  output out_user_t o_m_user
);

  cfg_t rd_cfg;
  logic latch;
  logic wr_bank;
  logic rd_bank;
  logic start;
  logic out_fire;
  logic blk_done;

  // header decode, one config per bank
  rot_cfg_decode u_decode (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_hdr     (i_s_user),
    .i_latch   (latch),
    .i_wr_bank (wr_bank),
    .i_rd_bank (rd_bank),
    .o_rd_cfg  (rd_cfg)
  );

  rot_pingpong_bank u_bank (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_s_valid  (i_s_valid),
    .i_s_last   (i_s_last),
    .i_s_data   (i_s_data),
    .o_s_ready  (o_s_ready),
    .i_addr_max (rd_cfg.addr_max),
    .i_m_ready  (i_m_ready),
    .i_blk_done (blk_done),
    .o_m_valid  (o_m_valid),
    .o_m_data   (o_m_data),
    .o_latch    (latch),
    .o_wr_bank  (wr_bank),
    .o_rd_bank  (rd_bank),
    .o_start    (start),
    .o_fire     (out_fire)
  );

  // loop position, gives tlast and the user flags
  rot_loop_counters u_counters (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_start    (start),
    .i_fire     (out_fire),
    .i_cfg      (rd_cfg),
    .o_blk_done (blk_done),
    .o_user     (o_m_user)
  );

  assign o_m_last = blk_done;

endmodule

/* design/rot_loop_counters.sv */
`timescale 1ns/100ps

module rot_loop_counters
  import rot_stream_pkg::*, rot_cfg_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      i_start,
  input  logic      i_fire,
  input  cfg_t      i_cfg,
  output logic      o_blk_done,
  output out_user_t o_user
);

  tap_t c_tap;
  ci_t  c_cin;
  xw_t  c_cols;
  blk_t c_blk;
  xn_t  c_xn;

  tap_t tap_max;
  xw_t  cols_left;

  logic l_tap;
  logic l_cin;
  logic l_cols;
  logic l_blk;
  logic l_xn;

  logic w_tap;
  logic w_cin;
  logic w_cols;
  logic w_blk;

  // taps run 0..2*kw2
  assign tap_max = tap_t'({i_cfg.kw2, 1'b0});

  assign l_tap  = (c_tap == tap_max);
  assign l_cin  = (c_cin == i_cfg.cin_1);
  assign l_cols = (c_cols == i_cfg.cols_1);
  assign l_blk  = (c_blk == i_cfg.blocks_1);
  assign l_xn   = (c_xn == i_cfg.xn_1);

  // each counter steps when the one inside it wraps
  assign w_tap  = i_fire && l_tap;
  assign w_cin  = w_tap && l_cin;
  assign w_cols = w_cin && l_cols;
  assign w_blk  = w_cols && l_blk;

  always_ff @(posedge aclk) begin
    if (!aresetn || i_start) begin
      c_tap  <= '0;
      c_cin  <= '0;
      c_cols <= '0;
      c_blk  <= '0;
      c_xn   <= '0;
    end else begin
      if (i_fire) begin
        c_tap <= l_tap ? '0 : c_tap + 1'b1;
      end
      if (w_tap) begin
        c_cin <= l_cin ? '0 : c_cin + 1'b1;
      end
      if (w_cin) begin
        c_cols <= l_cols ? '0 : c_cols + 1'b1;
      end
      if (w_cols) begin
        c_blk <= l_blk ? '0 : c_blk + 1'b1;
      end
      if (w_blk) begin
        c_xn <= l_xn ? '0 : c_xn + 1'b1;
      end
    end
  end

  // final beat of the whole replay
  assign o_blk_done = l_tap && l_cin && l_cols && l_blk && l_xn;

  // columns still to come after the current one
  assign cols_left = i_cfg.cols_1 - c_cols;

  assign o_user.kw2            = i_cfg.kw2;
  assign o_user.is_w_first_clk = (c_tap == '0) && (c_cin == '0) && (c_cols == '0);
  assign o_user.is_cin_last    = l_tap && l_cin;
  assign o_user.is_w_first_kw2 = cols_left < xw_t'(i_cfg.kw2);
  assign o_user.is_w_last      = l_cols;

endmodule

/* design/rot_pingpong_bank.sv */
`timescale 1ns/100ps
`include "rot_settings.svh"

module rot_pingpong_bank
  import rot_stream_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  input  logic  i_s_valid,
  input  logic  i_s_last,
  input  row_t  i_s_data,
  output logic  o_s_ready,
  input  addr_t i_addr_max,
  input  logic  i_m_ready,
  input  logic  i_blk_done,
  output logic  o_m_valid,
  output row_t  o_m_data,
  output logic  o_latch,
  output logic  o_wr_bank,
  output logic  o_rd_bank,
  output logic  o_start,
  output logic  o_fire
);

  typedef enum logic [1:0] {
    w_idle,
    w_write,
    w_switch
  } wr_state_e;

  typedef enum logic [1:0] {
    r_idle,
    r_read,
    r_switch
  } rd_state_e;

  wr_state_e  wr_state;
  rd_state_e  rd_state;

  row_t       mem [0:1][0:`ROT_DEPTH-1];
  logic [1:0] wr_done;
  logic       wr_bank;
  logic       rd_bank;
  addr_t      wr_addr;
  addr_t      rd_addr;
  row_t       out_row;
  logic       s_fire;
  logic       rd_step;
  logic       rd_finish;

  assign o_s_ready = (wr_state == w_write);
  assign s_fire    = i_s_valid && o_s_ready;
  assign o_latch   = s_fire && i_s_last;
  assign o_wr_bank = wr_bank;
  assign o_rd_bank = rd_bank;

  // write side, fills one bank from address 0
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_state <= w_idle;
      wr_bank  <= 1'b0;
      wr_addr  <= '0;
    end else begin
      case (wr_state)
        w_idle: begin
          // wait until the reader has released this bank
          if (!wr_done[wr_bank]) begin
            wr_state <= w_write;
          end
        end
        w_write: begin
          if (s_fire) begin
            wr_addr <= wr_addr + 1'b1;
          end
          if (o_latch) begin
            wr_state <= w_switch;
          end
        end
        w_switch: begin
          wr_bank  <= !wr_bank;
          wr_addr  <= '0;
          wr_state <= w_idle;
        end
        default: wr_state <= w_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire) begin
      mem[wr_bank][wr_addr] <= i_s_data;
    end
  end

  // set when a bank is full, cleared once its replay ends
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_done <= '0;
    end else begin
      if (wr_state == w_switch) begin
        wr_done[wr_bank] <= 1'b1;
      end
      if (rd_finish) begin
        wr_done[rd_bank] <= 1'b0;
      end
    end
  end

  assign o_m_valid = (rd_state == r_read);
  assign o_fire    = o_m_valid && i_m_ready;
  assign o_start   = (rd_state == r_idle) && wr_done[rd_bank];
  assign rd_finish = o_fire && i_blk_done;
  // first load on start, then one row per handshake
  assign rd_step   = o_start || (o_fire && !i_blk_done);

  // read side, cyclic over 0..addr_max
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_state <= r_idle;
      rd_bank  <= 1'b0;
      rd_addr  <= '0;
    end else begin
      if (rd_step) begin
        rd_addr <= (rd_addr == i_addr_max) ? '0 : rd_addr + 1'b1;
      end
      case (rd_state)
        r_idle: begin
          if (o_start) begin
            rd_state <= r_read;
          end
        end
        r_read: begin
          if (rd_finish) begin
            rd_state <= r_switch;
          end
        end
        r_switch: begin
          rd_bank  <= !rd_bank;
          rd_addr  <= '0;
          rd_state <= r_idle;
        end
        default: rd_state <= r_idle;
      endcase
    end
  end

  // output row, held while the sink stalls
  always_ff @(posedge aclk) begin
    if (rd_step) begin
      out_row <= mem[rd_bank][rd_addr];
    end
  end

  assign o_m_data = out_row;

endmodule

/* design/rot_cfg_decode.sv */
`timescale 1ns/100ps

module rot_cfg_decode
  import rot_cfg_pkg::*;
(
  input  logic aclk,
  input  logic aresetn,
  input  hdr_t i_hdr,
  input  logic i_latch,
  input  logic i_wr_bank,
  input  logic i_rd_bank,
  output cfg_t o_rd_cfg
);

  cfg_t       hdr_cfg;
  cfg_t [1:0] bank_cfg;

  // first pass uses its own address limit and channel count
  always_comb begin
    hdr_cfg.addr_max = i_hdr.is_first_p ? i_hdr.addr_p0_max : i_hdr.addr_p_max;
    hdr_cfg.xn_1     = i_hdr.xn_1;
    hdr_cfg.blocks_1 = i_hdr.blocks_1;
    hdr_cfg.cols_1   = i_hdr.cols_1;
    hdr_cfg.cin_1    = i_hdr.is_first_p ? i_hdr.cin_p0_1 : i_hdr.cin_p_1;
    hdr_cfg.kw2      = i_hdr.kw2;
  end

  // one register per bank, written with the last beat of its block
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bank_cfg <= '0;
    end else if (i_latch) begin
      bank_cfg[i_wr_bank] <= hdr_cfg;
    end
  end

  // the bank under replay sets the counters and the wrap point
  assign o_rd_cfg = bank_cfg[i_rd_bank];

endmodule

/* design/rot_cfg_pkg.sv */
`include "rot_settings.svh"

package rot_cfg_pkg;

  import rot_stream_pkg::*;

  // loop count widths, each holding count minus one
  typedef logic [KW2_W-1:0]                   kw2_t;
  typedef logic [$clog2(`ROT_CI_MAX)-1:0]     ci_t;
  typedef logic [$clog2(`ROT_XW_MAX)-1:0]     xw_t;
  typedef logic [$clog2(`ROT_BLOCKS_MAX)-1:0] blk_t;
  typedef logic [$clog2(`ROT_XN_MAX)-1:0]     xn_t;

  // kernel tap index, runs up to 2*kw2
  typedef logic [$clog2(`ROT_KW_MAX)-1:0]     tap_t;

  // header sampled with the last beat of a block
  typedef struct packed {
    addr_t addr_p_max;
    addr_t addr_p0_max;
    xn_t   xn_1;
    ci_t   cin_p_1;
    ci_t   cin_p0_1;
    blk_t  blocks_1;
    xw_t   cols_1;
    kw2_t  kw2;
    logic  is_first_p;
  } hdr_t;

  // decoded configuration kept per bank
  typedef struct packed {
    addr_t addr_max;
    xn_t   xn_1;
    blk_t  blocks_1;
    xw_t   cols_1;
    ci_t   cin_1;
    kw2_t  kw2;
  } cfg_t;

endpackage

/* design/rot_stream_pkg.sv */
`include "rot_settings.svh"

package rot_stream_pkg;

  // one weight, and one full row of weights
  typedef logic [`ROT_WORD_W-1:0] word_t;
  typedef word_t [`ROT_COLS-1:0] row_t;

  localparam int ADDR_W = $clog2(`ROT_DEPTH);

  // half the kernel width, also used by the header types
  localparam int KW2_W = $clog2((`ROT_KW_MAX + 1) / 2);

  // row address inside one bank
  typedef logic [ADDR_W-1:0] addr_t;

  // position flags sent with every output row
  typedef struct packed {
    logic [KW2_W-1:0] kw2;
    logic             is_w_first_clk;
    logic             is_cin_last;
    logic             is_w_first_kw2;
    logic             is_w_last;
  } out_user_t;

endpackage

/* include/rot_settings.svh */
`ifndef ROT_SETTINGS_SVH
`define ROT_SETTINGS_SVH

// words per row, one word per array column
`define ROT_COLS 4

// bits per weight
`define ROT_WORD_W 8

// rows per bank
`define ROT_DEPTH 32

// largest kernel width, must be odd
`define ROT_KW_MAX 7

// maxima of the replay loop counts
`define ROT_CI_MAX 8
`define ROT_XW_MAX 8
`define ROT_BLOCKS_MAX 4
`define ROT_XN_MAX 2

`endif
